// ==== compile.f ====
rtl/quat_pkg.sv
rtl/rate_sum_if.sv
rtl/quat_rate_lane.sv
rtl/quat_step_combine.sv
rtl/quat_integrator.sv
sim/quat_integrator_properties.sv
sim/quat_integrator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module quat_integrator_tb \
  -f compile.f -o quat_integrator_sim \
  && ./obj_dir/quat_integrator_sim | tee /dev/stderr | grep -qx "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sim/quat_integrator_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module quat_integrator_tb
  import quat_pkg::*;
();

  localparam int DONE_TIMEOUT = 40;  // cycles
  localparam int IDLE_TIMEOUT = 40;
  localparam int RANDOM_STEPS = 200;
  localparam int ZERO_STEPS   = 20;
  localparam int STEP_LATENCY = 9;   // accepting edge to done

  logic clk;
  logic rst;
  logic start;
  fix_t q0;
  fix_t q1;
  fix_t q2;
  fix_t q3;
  fix_t wx;
  fix_t wy;
  fix_t wz;
  fix_t q0_out;
  fix_t q1_out;
  fix_t q2_out;
  fix_t q3_out;
  logic done;
  logic busy;

  fix_t        q_in    [0:3];
  fix_t        w_in    [0:2];  // wx, wy, wz
  longint      exp_raw [0:3];  // before clamping
  fix_t        exp_q   [0:3];
  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          test_errors;
  bit          sat_max_seen;
  bit          sat_min_seen;

  quat_integrator dut (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .q0     (q0),
    .q1     (q1),
    .q2     (q2),
    .q3     (q3),
    .wx     (wx),
    .wy     (wy),
    .wz     (wz),
    .q0_out (q0_out),
    .q1_out (q1_out),
    .q2_out (q2_out),
    .q3_out (q3_out),
    .done   (done),
    .busy   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus source and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function fix_t rand_fix();
    rng_state = xorshift32(rng_state);
    return fix_t'(rng_state[23:8]);
  endfunction

  function automatic longint product(input fix_t a, input fix_t b);
    return longint'(a) * longint'(b);
  endfunction

  // standard kinematic form in Q8.24
  function automatic longint rate_sum(input int k);
    case (k)
      0: return -product(q_in[1], w_in[0]) - product(q_in[2], w_in[1])
                - product(q_in[3], w_in[2]);
      1: return product(q_in[0], w_in[0]) + product(q_in[2], w_in[2])
                - product(q_in[3], w_in[1]);
      2: return product(q_in[0], w_in[1]) - product(q_in[1], w_in[2])
                + product(q_in[3], w_in[0]);
      default: return product(q_in[0], w_in[2]) + product(q_in[1], w_in[1])
                - product(q_in[2], w_in[0]);
    endcase
  endfunction

  task automatic compute_expected();
    longint step;
    for (int k = 0; k < 4; k++) begin
      step = (rate_sum(k) * HALF_PERIOD) >>> (FRAC_BITS + HP_FRAC_BITS);  // floor
      exp_raw[k] = longint'(q_in[k]) + step;
      if (exp_raw[k] > 32767) begin
        exp_q[k] = 16'sh7fff;
      end else if (exp_raw[k] < -32768) begin
        exp_q[k] = 16'sh8000;
      end else begin
        exp_q[k] = fix_t'(exp_raw[k]);
      end
    end
  endtask

  // which clamp limits the DUT outputs reached
  task automatic note_clamping();
    fix_t got [0:3];
    got = '{q0_out, q1_out, q2_out, q3_out};
    for (int k = 0; k < 4; k++) begin
      if (exp_raw[k] > 32767 && got[k] == 16'sh7fff) begin
        sat_max_seen = 1'b1;
      end
      if (exp_raw[k] < -32768 && got[k] == 16'sh8000) begin
        sat_min_seen = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // checks and handshake
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic signed [63:0] got,
                       input logic signed [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    check("q0_out", q0_out, exp_q[0]);
    check("q1_out", q1_out, exp_q[1]);
    check("q2_out", q2_out, exp_q[2]);
    check("q3_out", q3_out, exp_q[3]);
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // called on a falling edge
  task automatic run_step(input bit second_start, output int latency);
    int n;
    n = 0;
    while (busy && n < IDLE_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      errors++;
      $display("Timeout at %0d ns: DUT never went idle", $time);
    end
    q0    = q_in[0];
    q1    = q_in[1];
    q2    = q_in[2];
    q3    = q_in[3];
    wx    = w_in[0];
    wy    = w_in[1];
    wz    = w_in[2];
    start = 1'b1;
    n     = 0;
    while (!done && n < DONE_TIMEOUT) begin
      @(negedge clk);
      n++;
      start = second_start && (n == 3);  // lands while busy
      if (start) begin
        q0 = ~q_in[0];
        q1 = ~q_in[1];
        q2 = ~q_in[2];
        q3 = ~q_in[3];
      end
    end
    latency = done ? n - 1 : -1;  // first falling edge follows the accepting edge
    if (!done) begin
      errors++;
      $display("Timeout at %0d ns: no done within %0d cycles", $time, DONE_TIMEOUT);
    end
  endtask

  initial begin
    int latency;
    int extra_done;
    rst   = 1'b0;
    start = 1'b0;
    q0    = '0;
    q1    = '0;
    q2    = '0;
    q3    = '0;
    wx    = '0;
    wy    = '0;
    wz    = '0;
    rng_state    = 32'h699b_1628;
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    sat_max_seen = 1'b0;
    sat_min_seen = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b1;

    check("done", done, 0);
    check("busy", busy, 0);
    exp_q = '{default: '0};
    check_outputs();
    report_test("reset values");

    for (int i = 0; i < RANDOM_STEPS; i++) begin
      for (int k = 0; k < 4; k++) q_in[k] = rand_fix();
      for (int k = 0; k < 3; k++) w_in[k] = rand_fix();
      compute_expected();
      run_step(1'b0, latency);
      check("latency", latency, STEP_LATENCY);
      check_outputs();
    end
    report_test("random steps");

    for (int i = 0; i < ZERO_STEPS; i++) begin
      for (int k = 0; k < 4; k++) q_in[k] = rand_fix();
      w_in = '{default: '0};
      run_step(1'b0, latency);
      check("q0_out", q0_out, q_in[0]);
      check("q1_out", q1_out, q_in[1]);
      check("q2_out", q2_out, q_in[2]);
      check("q3_out", q3_out, q_in[3]);
    end
    report_test("zero rates");

    // every corner of the input range
    for (int c = 0; c < 128; c++) begin
      for (int k = 0; k < 4; k++) q_in[k] = c[k] ? 16'sh7fff : 16'sh8000;
      for (int k = 0; k < 3; k++) w_in[k] = c[4 + k] ? 16'sh7fff : 16'sh8000;
      compute_expected();
      run_step(1'b0, latency);
      check_outputs();
      note_clamping();
    end
    check("sat_max_seen", sat_max_seen, 1);
    check("sat_min_seen", sat_min_seen, 1);
    report_test("saturation");

    for (int k = 0; k < 4; k++) q_in[k] = rand_fix();
    for (int k = 0; k < 3; k++) w_in[k] = rand_fix();
    compute_expected();
    run_step(1'b1, latency);
    check("latency", latency, STEP_LATENCY);
    check_outputs();
    extra_done = 0;
    repeat (12) begin
      @(negedge clk);
      if (done) extra_done++;
    end
    check("extra_done", extra_done, 0);
    check("busy", busy, 0);
    report_test("start while busy");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/quat_integrator_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module quat_integrator_properties (
  input logic clk,
  input logic rst,
  input logic done,
  input logic busy,
  input logic lane0_ovf,
  input logic lane1_ovf
);

  done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
    else $error("done held high for more than one cycle");

  done_in_busy: assert property (@(posedge clk) disable iff (!rst) done |-> busy)
    else $error("done raised while busy was low");

  // busy rises on the edge that accepts start
  done_latency: assert property (@(posedge clk) disable iff (!rst) $rose(busy) |-> ##9 done)
    else $error("done did not follow an accepted start after 9 cycles");

  no_overflow: assert property (@(posedge clk) disable iff (!rst) !(lane0_ovf || lane1_ovf))
    else $error("rate lane accumulator overflowed");

endmodule

bind quat_integrator quat_integrator_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .done      (done),
  .busy      (busy),
  .lane0_ovf (lane0_if.overflow),
  .lane1_ovf (lane1_if.overflow)
);

`default_nettype wire

// ==== rtl/quat_integrator.sv ====
`timescale 1ns/10ps
`default_nettype none

module quat_integrator
  import quat_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  fix_t q0,
  input  fix_t q1,
  input  fix_t q2,
  input  fix_t q3,
  input  fix_t wx,
  input  fix_t wy,
  input  fix_t wz,
  output fix_t q0_out,
  output fix_t q1_out,
  output fix_t q2_out,
  output fix_t q3_out,
  output logic done,
  output logic busy
);

  logic lane_start;

  rate_sum_if lane0_if ();
  rate_sum_if lane1_if ();

  // lanes only see a start the combiner also takes
  assign lane_start = start & ~busy;

  //////////////////////////////////////////////////
  // rate lanes, side by side
  //////////////////////////////////////////////////

  quat_rate_lane #(.LANE(0)) u_lane0 (
    .clk   (clk),
    .rst   (rst),
    .start (lane_start),
    .q0    (q0),
    .q1    (q1),
    .q2    (q2),
    .q3    (q3),
    .wx    (wx),
    .wy    (wy),
    .wz    (wz),
    .out   (lane0_if.lane)  // sums for q0, q1
  );

  quat_rate_lane #(.LANE(1)) u_lane1 (
    .clk   (clk),
    .rst   (rst),
    .start (lane_start),
    .q0    (q0),
    .q1    (q1),
    .q2    (q2),
    .q3    (q3),
    .wx    (wx),
    .wy    (wy),
    .wz    (wz),
    .out   (lane1_if.lane)  // sums for q2, q3
  );

  quat_step_combine u_combine (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .q0     (q0),
    .q1     (q1),
    .q2     (q2),
    .q3     (q3),
    .lane0  (lane0_if.combiner),
    .lane1  (lane1_if.combiner),
    .q0_out (q0_out),
    .q1_out (q1_out),
    .q2_out (q2_out),
    .q3_out (q3_out),
    .done   (done),
    .busy   (busy)
  );

endmodule

`default_nettype wire

// ==== rtl/quat_step_combine.sv ====
`timescale 1ns/10ps
`default_nettype none

module quat_step_combine
  import quat_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  fix_t q0,
  input  fix_t q1,
  input  fix_t q2,
  input  fix_t q3,
  rate_sum_if.combiner lane0,
  rate_sum_if.combiner lane1,
  output fix_t q0_out,
  output fix_t q1_out,
  output fix_t q2_out,
  output fix_t q3_out,
  output logic done,
  output logic busy
);

  // 1049 needs 12 signed bits
  localparam int SCALED_W = $bits(acc_t) + 12;
  localparam int SHIFT    = FRAC_BITS + HP_FRAC_BITS;  // Q8.24 * 2^-20 back to Q4.12

  logic accept;
  logic scale_vld;

  fix_t q_r    [0:3];
  fix_t step_r [0:3];
  acc_t sum_in [0:3];
  fix_t step_next [0:3];
  fix_t q_next    [0:3];

  logic signed [SCALED_W-1:0] scaled [0:3];
  logic signed [16:0]         q_ext  [0:3];

  function automatic fix_t sat_fix(input logic signed [16:0] v);
    if (v > FIX_MAX) begin
      return FIX_MAX;
    end
    if (v < FIX_MIN) begin
      return FIX_MIN;
    end
    return v[15:0];
  endfunction

  assign accept = start && !busy;

  // component order q0..q3
  assign sum_in[0] = lane0.sum_lo;
  assign sum_in[1] = lane0.sum_hi;
  assign sum_in[2] = lane1.sum_lo;
  assign sum_in[3] = lane1.sum_hi;

  //////////////////////////////////////////////////
  // scale by half period, then add and clamp
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      scaled[i]    = sum_in[i] * HALF_PERIOD;
      step_next[i] = fix_t'(scaled[i] >>> SHIFT);  // floor, magnitude stays small
      q_ext[i]     = q_r[i] + step_r[i];
      q_next[i]    = sat_fix(q_ext[i]);
    end
  end

  // captured q and scaled terms
  always_ff @(posedge clk) begin
    if (accept) begin
      q_r[0] <= q0;
      q_r[1] <= q1;
      q_r[2] <= q2;
      q_r[3] <= q3;
    end
    if (lane0.valid) begin  // lane 1 runs in lockstep
      for (int i = 0; i < 4; i++) begin
        step_r[i] <= step_next[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // handshake and outputs
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy      <= 1'b0;
      scale_vld <= 1'b0;
      done      <= 1'b0;
      q0_out    <= '0;
      q1_out    <= '0;
      q2_out    <= '0;
      q3_out    <= '0;
    end else begin
      scale_vld <= lane0.valid;
      done      <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;  // busy covers the done cycle
      end
      if (scale_vld) begin
        q0_out <= q_next[0];
        q1_out <= q_next[1];
        q2_out <= q_next[2];
        q3_out <= q_next[3];
        done   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/quat_rate_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module quat_rate_lane
  import quat_pkg::*;
#(
  parameter int LANE = 0  // 0: sums for q0/q1, 1: sums for q2/q3
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  fix_t q0,
  input  fix_t q1,
  input  fix_t q2,
  input  fix_t q3,
  input  fix_t wx,
  input  fix_t wy,
  input  fix_t wz,
  rate_sum_if.lane out
);

  localparam int MAC_STEPS = TERMS_PER_SUM * SUMS_PER_LANE;
  localparam int BASE      = LANE * MAC_STEPS;  // first table entry of this lane

  logic       busy;
  logic [2:0] cnt;
  logic       valid;
  logic       ovf;

  fix_t q_r [0:3];
  fix_t w_r [0:2];
  acc_t acc_lo;
  acc_t acc_hi;

  logic              accept;
  logic              mac_en;
  logic              hi_sel;
  logic [2:0]        step;
  logic [3:0]        tbl_idx;
  term_t             cur_term;
  fix_t              op_q;
  fix_t              op_w;
  logic signed [31:0] prod;
  logic signed [34:0] acc_ext;
  logic signed [34:0] prod_ext;
  logic signed [34:0] acc_sum;
  acc_t              acc_cur;
  logic              acc_ovf;

  assign accept = start && !busy;
  assign mac_en = busy && (cnt < MAC_STEPS);
  assign hi_sel = (cnt >= TERMS_PER_SUM);  // second sum of the lane

  // hold index in range on the idle step
  assign step     = mac_en ? cnt : 3'd0;
  assign tbl_idx  = 4'(BASE) + {1'b0, step};
  assign cur_term = TERM_TABLE[tbl_idx];

  //////////////////////////////////////////////////
  // operand select and single multiplier
  //////////////////////////////////////////////////

  always_comb begin
    case (cur_term.q_idx)
      2'd0:    op_q = q_r[0];
      2'd1:    op_q = q_r[1];
      2'd2:    op_q = q_r[2];
      default: op_q = q_r[3];
    endcase
    case (cur_term.w_idx)
      W_X:     op_w = w_r[0];
      W_Y:     op_w = w_r[1];
      default: op_w = w_r[2];  // W_Z
    endcase
  end

  assign prod     = op_q * op_w;  // Q8.24
  assign acc_cur  = hi_sel ? acc_hi : acc_lo;
  assign acc_ext  = acc_cur;
  assign prod_ext = prod;
  assign acc_sum  = cur_term.subtract ? (acc_ext - prod_ext) : (acc_ext + prod_ext);
  assign acc_ovf  = acc_sum[34] ^ acc_sum[33];  // result left acc_t

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy  <= 1'b0;
      cnt   <= 3'd0;
      valid <= 1'b0;
      ovf   <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        cnt  <= 3'd0;
        ovf  <= 1'b0;
      end else if (busy) begin
        if (cnt == 3'(LANE_CYCLES - 1)) begin
          valid <= 1'b1;  // sums settled one edge earlier
          busy  <= 1'b0;
        end else begin
          cnt <= cnt + 3'd1;
          if (mac_en && acc_ovf) begin
            ovf <= 1'b1;
          end
        end
      end
    end
  end

  // operands and accumulators
  always_ff @(posedge clk) begin
    if (accept) begin
      q_r[0] <= q0;
      q_r[1] <= q1;
      q_r[2] <= q2;
      q_r[3] <= q3;
      w_r[0] <= wx;
      w_r[1] <= wy;
      w_r[2] <= wz;
      acc_lo <= '0;
      acc_hi <= '0;
    end else if (mac_en) begin
      if (hi_sel) begin
        acc_hi <= acc_sum[33:0];
      end else begin
        acc_lo <= acc_sum[33:0];
      end
    end
  end

  assign out.valid    = valid;
  assign out.sum_lo   = acc_lo;
  assign out.sum_hi   = acc_hi;
  assign out.overflow = ovf;

endmodule

`default_nettype wire

// ==== rtl/rate_sum_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one lane's pair of rate sums, handed to the combiner
interface rate_sum_if
  import quat_pkg::*;
();

  logic valid;     // single-cycle pulse
  acc_t sum_lo;    // first component of the lane
  acc_t sum_hi;    // second component of the lane
  logic overflow;  // accumulator left its range

  modport lane (
    output valid, sum_lo, sum_hi, overflow
  );

  modport combiner (
    input valid, sum_lo, sum_hi, overflow
  );

endinterface

`default_nettype wire

// ==== rtl/quat_pkg.sv ====
`default_nettype none

package quat_pkg;

  //////////////////////////////////////////////////
  // fixed-point formats
  //////////////////////////////////////////////////

  typedef logic signed [15:0] fix_t;  // Q4.12 component or rate
  typedef logic signed [33:0] acc_t;  // Q8.24, three products summed

  localparam int FRAC_BITS = 12;

  localparam fix_t FIX_MAX = 16'sh7fff;
  localparam fix_t FIX_MIN = 16'sh8000;

  // half sample period, 0.001 s scaled by 2^20
  localparam int HALF_PERIOD  = 1049;
  localparam int HP_FRAC_BITS = 20;

  //////////////////////////////////////////////////
  // rate sum terms
  //////////////////////////////////////////////////

  localparam int TERMS_PER_SUM = 3;
  localparam int SUMS_PER_LANE = 2;
  localparam int LANE_CYCLES   = 7;  // accepted start to lane valid

  localparam logic [1:0] W_X = 2'd0;
  localparam logic [1:0] W_Y = 2'd1;
  localparam logic [1:0] W_Z = 2'd2;

  typedef struct packed {
    logic [1:0] q_idx;     // which q component
    logic [1:0] w_idx;     // which body rate
    logic       subtract;  // product enters with minus sign
  } term_t;

  // component 0..3, three terms each
  localparam term_t TERM_TABLE [0:11] = '{
    '{2'd1, W_X, 1'b1},  // q0: -q1*wx
    '{2'd2, W_Y, 1'b1},  //     -q2*wy
    '{2'd3, W_Z, 1'b1},  //     -q3*wz
    '{2'd0, W_X, 1'b0},  // q1: +q0*wx
    '{2'd2, W_Z, 1'b0},  //     +q2*wz
    '{2'd3, W_Y, 1'b1},  //     -q3*wy
    '{2'd0, W_Y, 1'b0},  // q2: +q0*wy
    '{2'd1, W_Z, 1'b1},  //     -q1*wz
    '{2'd3, W_X, 1'b0},  //     +q3*wx
    '{2'd0, W_Z, 1'b0},  // q3: +q0*wz
    '{2'd1, W_Y, 1'b0},  //     +q1*wy
    '{2'd2, W_X, 1'b1}   //     -q2*wx
  };

endpackage

`default_nettype wire
